/* logic/cpuPkg.sv */
package cpuPkg;

        localparam int IMEM_WORDS = 1024;
        localparam int IMEM_AW = $clog2(IMEM_WORDS);
        localparam int DMEM_WORDS = 1024;
        localparam int DMEM_AW = $clog2(DMEM_WORDS);

        // value in register 2 that makes syscall stop the core
        localparam logic [31:0] HALT_CODE = 32'd10;

        typedef enum logic [5:0] {
                OP_SPECIAL = 6'h00,
                OP_J       = 6'h02,
                OP_JAL     = 6'h03,
                OP_BEQ     = 6'h04,
                OP_BNE     = 6'h05,
                OP_ADDI    = 6'h08,
                OP_ANDI    = 6'h0c,
                OP_ORI     = 6'h0d,
                OP_LUI     = 6'h0f,
                OP_LW      = 6'h23,
                OP_SW      = 6'h2b
        } opcodeT;

        typedef enum logic [5:0] {
                F_SLL     = 6'h00,
                F_SRL     = 6'h02,
                F_JR      = 6'h08,
                F_SYSCALL = 6'h0c,
                F_ADD     = 6'h20,
                F_SUB     = 6'h22,
                F_AND     = 6'h24,
                F_OR      = 6'h25,
                F_SLT     = 6'h2a
        } functT;

        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_SLT,
                ALU_SLL,
                ALU_SRL,
                ALU_LUI
        } aluOpT;

        typedef struct packed {
                aluOpT aluOp;
                logic  aluSrcImm;
                logic  regWrite;
                logic  memRead;
                logic  memWrite;
                logic  isBeq;
                logic  isBne;
                logic  isJump;
                logic  isJal;
                logic  isJr;
                logic  isSyscall;
                // shifts take rt as the operand and shamt as the amount
                logic  shiftByShamt;
        } ctrlT;

endpackage

/* logic/stageBus.sv */
`timescale 1ns/1ps

// one instruction between ID/EX and the execute stage
interface decExBus;
        import cpuPkg::*;

        ctrlT        ctrl;
        logic [31:0] rsValue;
        logic [31:0] rtValue;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [25:0] jumpIndex;
        logic [4:0]  dest;
        logic [31:0] pcPlus4;
        logic        valid;

        modport src(output ctrl, rsValue, rtValue, imm, shamt, jumpIndex, dest, pcPlus4, valid);
        modport dst(input ctrl, rsValue, rtValue, imm, shamt, jumpIndex, dest, pcPlus4, valid);
endinterface

// one instruction held in EX/MEM
interface exMemBus;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic        isJal;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  dest;
        logic [31:0] pcPlus4;
        logic        valid;

        modport src(output regWrite, memRead, memWrite, isJal, aluResult, storeData, dest,
                pcPlus4, valid);
        modport dst(input regWrite, memRead, memWrite, isJal, aluResult, storeData, dest,
                pcPlus4, valid);
endinterface

/* logic/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
        input  logic                      clk,
        input  logic                      reset,
        input  logic                      go,
        input  logic                      redirect,
        input  logic                      haltReq,
        input  logic [31:0]               target,
        input  logic                      imemWe,
        input  logic [cpuPkg::IMEM_AW-1:0] imemAddr,
        input  logic [31:0]               imemData,
        output logic [31:0]               instr,
        output logic [31:0]               pcPlus4,
        output logic                      valid,
        output logic                      halted
);
        import cpuPkg::*;

        logic [31:0] imem [IMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] fetched;

        assign fetched = imem[pc[IMEM_AW+1:2]];

        // program load port used only while halted
        always_ff @(posedge clk) begin
                if (imemWe)
                        imem[imemAddr] <= imemData;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc <= '0;
                        halted <= 1'b1;
                end else if (redirect || haltReq) begin
                        // on halt, target is the syscall's pcPlus4
                        pc <= target;
                        halted <= haltReq | halted;
                end else if (halted) begin
                        halted <= ~go;
                end else begin
                        pc <= pc + 32'd4;
                end
        end

        // IF/ID register
        always_ff @(posedge clk) begin
                if (reset)
                        valid <= 1'b0;
                else
                        valid <= ~halted & ~redirect & ~haltReq;
        end

        always_ff @(posedge clk) begin
                instr <= fetched;
                pcPlus4 <= pc + 32'd4;
        end
endmodule

/* logic/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
        input  logic        clk,
        input  logic        reset,
        input  logic [31:0] instr,
        input  logic [31:0] pcPlus4,
        input  logic        valid,
        input  logic        flush,
        input  logic        wbWrite,
        input  logic [4:0]  wbDest,
        input  logic [31:0] wbData,
        decExBus.src        dx
);
        import cpuPkg::*;

        logic [31:0] regs [32];
        opcodeT      op;
        functT       fn;
        ctrlT        ctrl;
        logic [4:0]  rsAddr;
        logic [4:0]  rtAddr;
        logic [31:0] rsValue;
        logic [31:0] rtValue;
        logic [31:0] imm;
        logic [4:0]  dest;

        assign op = opcodeT'(instr[31:26]);
        assign fn = functT'(instr[5:0]);

        always_comb begin
                ctrl = '0;
                ctrl.aluOp = ALU_ADD;
                case (op)
                        OP_SPECIAL: begin
                                case (fn)
                                        F_ADD: ctrl.regWrite = 1'b1;
                                        F_SUB: {ctrl.aluOp, ctrl.regWrite} = {ALU_SUB, 1'b1};
                                        F_AND: {ctrl.aluOp, ctrl.regWrite} = {ALU_AND, 1'b1};
                                        F_OR:  {ctrl.aluOp, ctrl.regWrite} = {ALU_OR, 1'b1};
                                        F_SLT: {ctrl.aluOp, ctrl.regWrite} = {ALU_SLT, 1'b1};
                                        F_SLL: begin
                                                ctrl.aluOp = ALU_SLL;
                                                ctrl.regWrite = 1'b1;
                                                ctrl.shiftByShamt = 1'b1;
                                        end
                                        F_SRL: begin
                                                ctrl.aluOp = ALU_SRL;
                                                ctrl.regWrite = 1'b1;
                                                ctrl.shiftByShamt = 1'b1;
                                        end
                                        F_JR:      ctrl.isJr = 1'b1;
                                        F_SYSCALL: ctrl.isSyscall = 1'b1;
                                        default:   ;
                                endcase
                        end
                        OP_J:    ctrl.isJump = 1'b1;
                        OP_JAL:  {ctrl.isJump, ctrl.isJal, ctrl.regWrite} = 3'b111;
                        OP_BEQ:  ctrl.isBeq = 1'b1;
                        OP_BNE:  ctrl.isBne = 1'b1;
                        OP_ADDI: {ctrl.aluSrcImm, ctrl.regWrite} = 2'b11;
                        OP_ANDI: {ctrl.aluOp, ctrl.aluSrcImm, ctrl.regWrite} = {ALU_AND, 2'b11};
                        OP_ORI:  {ctrl.aluOp, ctrl.aluSrcImm, ctrl.regWrite} = {ALU_OR, 2'b11};
                        OP_LUI:  {ctrl.aluOp, ctrl.aluSrcImm, ctrl.regWrite} = {ALU_LUI, 2'b11};
                        OP_LW:   {ctrl.aluSrcImm, ctrl.regWrite, ctrl.memRead} = 3'b111;
                        OP_SW:   {ctrl.aluSrcImm, ctrl.memWrite} = 2'b11;
                        default: ;
                endcase
        end

        // syscall reads its code from r2 and its display value from r4
        assign rsAddr = ctrl.isSyscall ? 5'd2 : instr[25:21];
        assign rtAddr = ctrl.isSyscall ? 5'd4 : instr[20:16];

        // write-through so WB and ID can share a cycle
        assign rsValue = (rsAddr == 5'd0) ? 32'd0 :
                (wbWrite && wbDest == rsAddr) ? wbData : regs[rsAddr];
        assign rtValue = (rtAddr == 5'd0) ? 32'd0 :
                (wbWrite && wbDest == rtAddr) ? wbData : regs[rtAddr];

        always_ff @(posedge clk) begin
                if (wbWrite && wbDest != 5'd0)
                        regs[wbDest] <= wbData;
        end

        assign imm = (op == OP_ANDI || op == OP_ORI) ? {16'd0, instr[15:0]} :
                {{16{instr[15]}}, instr[15:0]};
        assign dest = ctrl.isJal ? 5'd31 : (op == OP_SPECIAL) ? instr[15:11] : instr[20:16];

        // ID/EX register
        always_ff @(posedge clk) begin
                if (reset)
                        dx.valid <= 1'b0;
                else
                        dx.valid <= valid & ~flush;
        end

        always_ff @(posedge clk) begin
                dx.ctrl <= ctrl;
                dx.rsValue <= rsValue;
                dx.rtValue <= rtValue;
                dx.imm <= imm;
                dx.shamt <= instr[10:6];
                dx.jumpIndex <= instr[25:0];
                dx.dest <= dest;
                dx.pcPlus4 <= pcPlus4;
        end
endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
        input  logic        clk,
        input  logic        reset,
        decExBus.dst        dx,
        exMemBus.src        xm,
        output logic        redirect,
        output logic [31:0] target,
        output logic        haltReq,
        output logic        showReq,
        output logic [31:0] showValue,
        output logic        branchTaken,
        output logic        jumpTaken
);
        import cpuPkg::*;

        logic [31:0] aluA;
        logic [31:0] aluB;
        logic [31:0] aluResult;
        logic        equal;
        logic        syscallHere;

        assign aluA = dx.ctrl.shiftByShamt ? dx.rtValue : dx.rsValue;
        assign aluB = dx.ctrl.aluSrcImm ? dx.imm : dx.rtValue;

        always_comb begin
                case (dx.ctrl.aluOp)
                        ALU_ADD: aluResult = aluA + aluB;
                        ALU_SUB: aluResult = aluA - aluB;
                        ALU_AND: aluResult = aluA & aluB;
                        ALU_OR:  aluResult = aluA | aluB;
                        ALU_SLT: aluResult = {31'd0, $signed(aluA) < $signed(aluB)};
                        ALU_SLL: aluResult = aluA << dx.shamt;
                        ALU_SRL: aluResult = aluA >> dx.shamt;
                        ALU_LUI: aluResult = {aluB[15:0], 16'd0};
                        default: aluResult = aluA + aluB;
                endcase
        end

        assign equal = (dx.rsValue == dx.rtValue);

        assign branchTaken = dx.valid & ((dx.ctrl.isBeq & equal) | (dx.ctrl.isBne & ~equal));
        assign jumpTaken = dx.valid & (dx.ctrl.isJump | dx.ctrl.isJr);
        assign redirect = branchTaken | jumpTaken;

        // a halting syscall restarts at the instruction after it
        always_comb begin
                if (dx.ctrl.isJr)
                        target = dx.rsValue;
                else if (dx.ctrl.isJump)
                        target = {dx.pcPlus4[31:28], dx.jumpIndex, 2'b00};
                else if (dx.ctrl.isSyscall)
                        target = dx.pcPlus4;
                else
                        target = dx.pcPlus4 + {dx.imm[29:0], 2'b00};
        end

        assign syscallHere = dx.valid & dx.ctrl.isSyscall;
        assign haltReq = syscallHere & (dx.rsValue == HALT_CODE);
        assign showReq = syscallHere & (dx.rsValue != HALT_CODE);
        assign showValue = dx.rtValue;

        // EX/MEM register
        always_ff @(posedge clk) begin
                if (reset)
                        xm.valid <= 1'b0;
                else
                        xm.valid <= dx.valid;
        end

        always_ff @(posedge clk) begin
                xm.regWrite <= dx.ctrl.regWrite;
                xm.memRead <= dx.ctrl.memRead;
                xm.memWrite <= dx.ctrl.memWrite;
                xm.isJal <= dx.ctrl.isJal;
                xm.aluResult <= aluResult;
                xm.storeData <= dx.rtValue;
                xm.dest <= dx.dest;
                xm.pcPlus4 <= dx.pcPlus4;
        end
endmodule

/* logic/memWriteback.sv */
`timescale 1ns/1ps

module memWriteback (
        input  logic        clk,
        input  logic        reset,
        exMemBus.dst        xm,
        output logic        wbWrite,
        output logic [4:0]  wbDest,
        output logic [31:0] wbData
);
        import cpuPkg::*;

        logic [31:0]        dmem [DMEM_WORDS];
        logic [DMEM_AW-1:0] wordAddr;
        logic [31:0]        loadData;
        logic [31:0]        resultData;

        // word addressed with the low two bits ignored
        assign wordAddr = xm.aluResult[DMEM_AW+1:2];
        assign loadData = dmem[wordAddr];

        always_ff @(posedge clk) begin
                if (xm.valid && xm.memWrite)
                        dmem[wordAddr] <= xm.storeData;
        end

        always_comb begin
                if (xm.memRead)
                        resultData = loadData;
                else if (xm.isJal)
                        resultData = xm.pcPlus4;
                else
                        resultData = xm.aluResult;
        end

        // MEM/WB register
        always_ff @(posedge clk) begin
                if (reset)
                        wbWrite <= 1'b0;
                else
                        wbWrite <= xm.valid & xm.regWrite;
        end

        always_ff @(posedge clk) begin
                wbDest <= xm.dest;
                wbData <= resultData;
        end
endmodule

/* logic/statusUnit.sv */
`timescale 1ns/1ps

module statusUnit (
        input  logic        clk,
        input  logic        reset,
        input  logic        halted,
        input  logic        branchTaken,
        input  logic        jumpTaken,
        input  logic        showReq,
        input  logic [31:0] showValue,
        output logic [31:0] ledData,
        output logic [31:0] countAll,
        output logic [31:0] countBranch,
        output logic [31:0] countJump
);

        always_ff @(posedge clk) begin
                if (reset) begin
                        countAll <= '0;
                        countBranch <= '0;
                        countJump <= '0;
                        ledData <= '0;
                end else begin
                        // cycles only count while the core runs
                        if (!halted)
                                countAll <= countAll + 32'd1;
                        if (branchTaken)
                                countBranch <= countBranch + 32'd1;
                        if (jumpTaken)
                                countJump <= countJump + 32'd1;
                        if (showReq)
                                ledData <= showValue;
                end
        end
endmodule

/* logic/pipelineCpu.sv */
`timescale 1ns/1ps

module pipelineCpu (
        input  logic                      clk,
        input  logic                      reset,
        input  logic                      go,
        input  logic                      imemWe,
        input  logic [cpuPkg::IMEM_AW-1:0] imemAddr,
        input  logic [31:0]               imemData,
        output logic [31:0]               ledData,
        output logic [31:0]               countAll,
        output logic [31:0]               countBranch,
        output logic [31:0]               countJump,
        output logic                      halted
);

        logic [31:0] instr;
        logic [31:0] pcPlus4;
        logic        valid;
        logic        redirect;
        logic [31:0] target;
        logic        haltReq;
        logic        showReq;
        logic [31:0] showValue;
        logic        branchTaken;
        logic        jumpTaken;
        logic        wbWrite;
        logic [4:0]  wbDest;
        logic [31:0] wbData;

        decExBus dx();
        exMemBus xm();

        fetchStage uFetch (.clk, .reset, .go, .redirect, .haltReq, .target, .imemWe, .imemAddr,
                .imemData, .instr, .pcPlus4, .valid, .halted);

        // younger instructions are dropped on a transfer or a halt
        decodeStage uDecode (.clk, .reset, .instr, .pcPlus4, .valid,
                .flush(redirect | haltReq), .wbWrite, .wbDest, .wbData, .dx(dx));

        executeStage uExecute (.clk, .reset, .dx(dx), .xm(xm), .redirect, .target, .haltReq,
                .showReq, .showValue, .branchTaken, .jumpTaken);

        memWriteback uMem (.clk, .reset, .xm(xm), .wbWrite, .wbDest, .wbData);

        statusUnit uStatus (.clk, .reset, .halted, .branchTaken, .jumpTaken, .showReq,
                .showValue, .ledData, .countAll, .countBranch, .countJump);
endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

// free-running 8 ns clock
module clockGen (
        output logic clk
);

        initial begin
                clk = 1'b0;
        end

        always begin
                #4 clk = ~clk;
        end
endmodule

/* sim/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
        import cpuPkg::*;

        logic               clk;
        logic               reset;
        logic               go;
        logic               imemWe;
        logic [IMEM_AW-1:0] imemAddr;
        logic [31:0]        imemData;
        logic [31:0]        ledData;
        logic [31:0]        countAll;
        logic [31:0]        countBranch;
        logic [31:0]        countJump;
        logic               halted;

        // test data flattened and tagged with the test index
        string       testNames[$];
        int          progTest[$];
        logic [31:0] progAddr[$];
        logic [31:0] progWord[$];
        int          ledTest[$];
        logic [31:0] ledValue[$];
        int          cntTest[$];
        logic [31:0] cntAllQ[$];
        logic [31:0] cntBranchQ[$];
        logic [31:0] cntJumpQ[$];
        logic [31:0] expectedLed[$];
        logic        loaded;

        clockGen uClock (.clk(clk));

        pipelineCpu u_dut (.clk, .reset, .go, .imemWe, .imemAddr, .imemData, .ledData,
                .countAll, .countBranch, .countJump, .halted);

        task automatic checkValue(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name,
                                expected, actual);
                        $display("Result: FAILED");
                        $fatal(1, "value check failed");
                end
        endtask

        task automatic failRun(input string reason);
                $display("%s", reason);
                $display("Result: FAILED");
                $fatal(1, "run aborted");
        endtask

        task automatic readTests();
                int          fd;
                int          code;
                int          cur;
                string       line;
                string       name;
                logic [31:0] a;
                logic [31:0] w;
                logic [31:0] x;
                logic [31:0] y;
                logic [31:0] z;
                cur = -1;
                fd = $fopen("sim/cpu_tests.txt", "r");
                if (fd == 0)
                        failRun("could not open the test file sim/cpu_tests.txt");
                while (!$feof(fd)) begin
                        line = "";
                        code = $fgets(line, fd);
                        if (code != 0 && line.len() > 1) begin
                                case (line.getc(0))
                                        "T": begin
                                                code = $sscanf(line, "T %s", name);
                                                testNames.push_back(name);
                                                cur = testNames.size() - 1;
                                        end
                                        "P": begin
                                                code = $sscanf(line, "P %h %h", a, w);
                                                progTest.push_back(cur);
                                                progAddr.push_back(a);
                                                progWord.push_back(w);
                                        end
                                        "L": begin
                                                code = $sscanf(line, "L %h", a);
                                                ledTest.push_back(cur);
                                                ledValue.push_back(a);
                                        end
                                        "C": begin
                                                code = $sscanf(line, "C %d %d %d", x, y, z);
                                                cntTest.push_back(cur);
                                                cntAllQ.push_back(x);
                                                cntBranchQ.push_back(y);
                                                cntJumpQ.push_back(z);
                                        end
                                        default: ;
                                endcase
                        end
                end
                $fclose(fd);
        endtask

        task automatic applyReset();
                @(posedge clk);
                #1 reset = 1'b1;
                repeat (5) @(posedge clk);
                #1 reset = 1'b0;
        endtask

        // core is halted here, so the load port is free
        task automatic loadProgram(input int t);
                foreach (progTest[i]) begin
                        if (progTest[i] == t) begin
                                @(posedge clk);
                                #1;
                                imemWe = 1'b1;
                                imemAddr = progAddr[i][IMEM_AW-1:0];
                                imemData = progWord[i];
                        end
                end
                @(posedge clk);
                #1 imemWe = 1'b0;
        endtask

        // one go pulse, then watch ledData until the next halt
        task automatic runToHalt(input int c);
                logic [31:0] prevLed;
                logic        done;
                prevLed = ledData;
                done = 1'b0;
                @(posedge clk);
                #1 go = 1'b1;
                @(posedge clk);
                #1 go = 1'b0;
                checkValue("halted", 32'd0, {31'd0, halted});
                while (!done) begin
                        @(negedge clk);
                        if (ledData !== prevLed) begin
                                if (expectedLed.size() == 0)
                                        failRun("ledData changed although no update was expected");
                                checkValue("ledData", expectedLed.pop_front(), ledData);
                                prevLed = ledData;
                        end
                        if (halted)
                                done = 1'b1;
                end
                checkValue("countAll", cntAllQ[c], countAll);
                checkValue("countBranch", cntBranchQ[c], countBranch);
                checkValue("countJump", cntJumpQ[c], countJump);
        endtask

        initial begin
                reset = 1'b1;
                go = 1'b0;
                imemWe = 1'b0;
                imemAddr = '0;
                imemData = '0;
                loaded = 1'b0;
                readTests();
                loaded = 1'b1;
                foreach (testNames[t]) begin
                        $display("running test %s", testNames[t]);
                        applyReset();
                        checkValue("halted", 32'd1, {31'd0, halted});
                        loadProgram(t);
                        expectedLed.delete();
                        foreach (ledTest[i]) begin
                                if (ledTest[i] == t)
                                        expectedLed.push_back(ledValue[i]);
                        end
                        foreach (cntTest[c]) begin
                                if (cntTest[c] == t)
                                        runToHalt(c);
                        end
                        if (expectedLed.size() != 0)
                                failRun($sformatf("test %s halted with %0d ledData updates missing",
                                        testNames[t], expectedLed.size()));
                end
                $display("Result: PASSED");
                $finish;
        end

        // limit grows with the amount of program in the file
        initial begin
                wait (loaded);
                repeat (progWord.size() * 200) @(posedge clk);
                $display("timeout: the core never halted within %0d cycles",
                        progWord.size() * 200);
                $display("Result: FAILED");
                $fatal(1, "watchdog expired");
        end
endmodule

/* flist.f */
logic/cpuPkg.sv
logic/stageBus.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/statusUnit.sv
logic/pipelineCpu.sv
sim/clockGen.sv
sim/cpuTb.sv

/* Bender.yml */
package:
  name: pipeline_cpu

sources:
  - files:
      - logic/cpuPkg.sv
      - logic/stageBus.sv
      - logic/fetchStage.sv
      - logic/decodeStage.sv
      - logic/executeStage.sv
      - logic/memWriteback.sv
      - logic/statusUnit.sv
      - logic/pipelineCpu.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/cpuTb.sv

/* sim/cpu_tests.txt */
# T name | P word-address instruction (hex) | L expected ledData (hex)
# C countAll countBranch countJump at each halt (decimal)
T alu_and_memory
P 00 20020001
P 01 20080007
P 02 2009fffd
P 03 3c0a1234
P 04 340bff0f
P 05 200c0040
P 06 01092020
P 07 00086900
P 08 00097702
P 09 ad8a0000
P 0a 0000000c
P 0b 01092022
P 0c 8d8f0000
P 0d 20000005
P 0e 0128802a
P 0f 0000000c
P 10 014b2025
P 11 01698824
P 12 01ae9020
P 13 01e09820
P 14 0000000c
P 15 02302020
P 16 00000000
P 17 00000000
P 18 00000000
P 19 0000000c
P 1a 02532020
P 1b 00000000
P 1c 00000000
P 1d 00000000
P 1e 0000000c
P 1f 2002000a
P 20 00000000
P 21 00000000
P 22 00000000
P 23 0000000c
L 00000004
L 0000000a
L 1234ff0f
L 0000ff0e
L 1234007f
C 38 0 0
T branch_jump_resume
P 00 20020001
P 01 20080005
P 02 20090005
P 03 20040011
P 04 200a0003
P 05 00000000
P 06 11090002
P 07 20040099
P 08 2002000a
P 09 15090005
P 0a 0000000c
P 0b 150a0002
P 0c 20040099
P 0d 2002000a
P 0e 0c000014
P 0f 0000000c
P 10 0800001a
P 11 20040099
P 12 2002000a
P 14 20040033
P 15 00000000
P 16 03e00008
P 17 20040099
P 18 2002000a
P 1a 2002000a
P 1b 03e02020
P 1c 00000000
P 1d 00000000
P 1e 0000000c
P 1f 20020001
P 20 00000000
P 21 00000000
P 22 00000000
P 23 0000000c
P 24 0800001a
L 00000011
L 00000033
L 0000003c
C 33 2 3
C 48 2 4
